// ==== dvbs2x_sample_pkg.sv ====
// ##############################
// sample stream struct, rate selection,
// rate table and hold stage count.
// ##############################

`default_nettype none

package dvbs2x_sample_pkg;

    localparam int SYMB_RATE_SEL_NB = 2;            // selection field width.

    // one entry per supported symbol rate.
    typedef enum logic [SYMB_RATE_SEL_NB-1:0] {
        TX_SYMB_RATE_QUARTER = 2'd0,                // divide by four.
        TX_SYMB_RATE_HALF    = 2'd1,                // divide by two.
        TX_SYMB_RATE_FULL    = 2'd2                 // no division.
    } symb_rate_sel_t;

    localparam int NUM_TX_SYMB_RATES = 3;

    // symbol rate in msps, indexed by selection.
    localparam int SYMB_RATE_MSPS [0:NUM_TX_SYMB_RATES-1] = '{25, 50, 100};

    localparam symb_rate_sel_t DEFAULT_SYMB_RATE_SEL = TX_SYMB_RATE_FULL; // also the fallback.

    // each stage halves the rate, so one less than the rate count.
    localparam int NUM_HOLD_STAGES = NUM_TX_SYMB_RATES - 1;

    localparam int SAMPLE_NB = 16;                  // i and q width.

    // one i/q sample plus frame marker.
    typedef struct packed {
        logic signed [SAMPLE_NB-1:0] i;
        logic signed [SAMPLE_NB-1:0] q;
        logic                        last;          // end of burst.
    } sample_t;

endpackage

`default_nettype wire

// ==== dvbs2x_tx_symb_rate_divider_mmi.sv ====
// ##############################
// symbol rate divider top level.
// ##############################

`timescale 1ns/1ps
`default_nettype none

module dvbs2x_tx_symb_rate_divider_mmi (
    input  logic                       clk_mmi,
    input  logic                       sresetn_mmi_interconnect,
    input  mmi_pkg::mmi_req_t          mmi_req,
    output mmi_pkg::mmi_rsp_t          mmi_rsp,
    input  dvbs2x_sample_pkg::sample_t in_sample,
    input  logic                       in_valid,
    output logic                       in_ready,
    output dvbs2x_sample_pkg::sample_t out_sample,
    output logic                       out_valid,
    input  logic                       out_ready
);

    import dvbs2x_sample_pkg::*;

    logic [NUM_HOLD_STAGES-1:0] hold_en;            // one per stage.
    sample_t                    link_sample [0:NUM_HOLD_STAGES]; // link k feeds stage k.
    logic [NUM_HOLD_STAGES:0]   link_valid;
    logic [NUM_HOLD_STAGES:0]   link_ready;

    symb_rate_regs symb_rate_regs_i (
        .clk_mmi                  (clk_mmi),
        .sresetn_mmi_interconnect (sresetn_mmi_interconnect),
        .mmi_req                  (mmi_req),
        .mmi_rsp                  (mmi_rsp),
        .hold_en                  (hold_en)
    );

    // chain entry.
    assign link_sample[0] = in_sample;
    assign link_valid[0]  = in_valid;
    assign in_ready       = link_ready[0];

    for (genvar g = 0; g < NUM_HOLD_STAGES; g++) begin : gen_hold
        rate_hold_stage rate_hold_stage_i (
            .clk_mmi                  (clk_mmi),
            .sresetn_mmi_interconnect (sresetn_mmi_interconnect),
            .hold_en                  (hold_en[g]),
            .in_sample                (link_sample[g]),
            .in_valid                 (link_valid[g]),
            .in_ready                 (link_ready[g]),
            .out_sample               (link_sample[g+1]),
            .out_valid                (link_valid[g+1]),
            .out_ready                (link_ready[g+1])
        );
    end

    // registered ready back into the chain.
    tx_sample_egress tx_sample_egress_i (
        .clk_mmi                  (clk_mmi),
        .sresetn_mmi_interconnect (sresetn_mmi_interconnect),
        .in_sample                (link_sample[NUM_HOLD_STAGES]),
        .in_valid                 (link_valid[NUM_HOLD_STAGES]),
        .in_ready                 (link_ready[NUM_HOLD_STAGES]),
        .out_sample               (out_sample),
        .out_valid                (out_valid),
        .out_ready                (out_ready)
    );

endmodule

`default_nettype wire

// ==== mmi_pkg.sv ====
// ##############################
// memory-mapped bus widths, register map
// and request/response structs.
// ##############################

`default_nettype none

package mmi_pkg;

    // bus widths.
    localparam int MMI_ADDR_NB = 8;                 // word address width.
    localparam int MMI_DATA_NB = 32;                // data word width.

    // register map.
    localparam logic [MMI_ADDR_NB-1:0] ADDR_SYMB_RATE     = 8'd0; // rw, rate in msps.
    localparam logic [MMI_ADDR_NB-1:0] ADDR_SYMB_RATE_SEL = 8'd1; // ro, decoded selection.
    localparam int TOTAL_MMI_REGS = 2;              // reads at or above return zero.
    localparam int MMI_REG_IDX_NB = $clog2(TOTAL_MMI_REGS); // index into the register array.

    // host to register block.
    typedef struct packed {
        logic                   wvalid;             // write strobe.
        logic [MMI_ADDR_NB-1:0] waddr;
        logic [MMI_DATA_NB-1:0] wdata;
        logic                   arvalid;            // read request.
        logic [MMI_ADDR_NB-1:0] raddr;
        logic                   rready;             // host takes read data.
    } mmi_req_t;

    // register block to host.
    typedef struct packed {
        logic                   wready;
        logic                   arready;
        logic                   rvalid;             // held until rready.
        logic [MMI_DATA_NB-1:0] rdata;
    } mmi_rsp_t;

endpackage

`default_nettype wire

// ==== rate_hold_stage.sv ====
// ##############################
// stream stage that can emit each
// sample twice.
// ##############################

`timescale 1ns/1ps
`default_nettype none

module rate_hold_stage (
    input  logic                       clk_mmi,
    input  logic                       sresetn_mmi_interconnect,
    input  logic                       hold_en,
    input  dvbs2x_sample_pkg::sample_t in_sample,
    input  logic                       in_valid,
    output logic                       in_ready,
    output dvbs2x_sample_pkg::sample_t out_sample,
    output logic                       out_valid,
    input  logic                       out_ready
);

    import dvbs2x_sample_pkg::*;

    sample_t held;                                  // output register.
    logic    held_valid;
    logic    dup_pending;                           // second copy still owed.
    logic    in_take;
    logic    out_take;

    assign in_take  = in_valid && in_ready;
    assign out_take = held_valid && out_ready;

    // free when empty, or when the final copy leaves this cycle.
    assign in_ready = !held_valid || (out_ready && !dup_pending);

    // control state.
    always_ff @(posedge clk_mmi) begin
        if (!sresetn_mmi_interconnect) begin
            held_valid  <= 1'b0;
            dup_pending <= 1'b0;
        end else if (in_take) begin
            held_valid  <= 1'b1;
            dup_pending <= hold_en;                 // latched per sample.
        end else if (out_take) begin
            if (dup_pending) begin
                dup_pending <= 1'b0;                // first copy gone, repeat.
            end else begin
                held_valid  <= 1'b0;
            end
        end
    end

    // payload.
    always_ff @(posedge clk_mmi) begin
        if (in_take) begin
            held <= in_sample;
        end
    end

    // last only rides on the final copy.
    always_comb begin
        out_sample      = held;
        out_sample.last = held.last && !dup_pending;
    end

    assign out_valid = held_valid;

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

TOP=tb_symb_rate_divider
OBJ_DIR=obj_dir
LOG=sim.log

rm -rf "$OBJ_DIR" "$LOG"

verilator --binary --timing --assert -Wno-fatal \
    -f src.f \
    --top-module "$TOP" \
    -Mdir "$OBJ_DIR"
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$OBJ_DIR/V$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Test passed" "$LOG"; then
    exit 0
else
    echo "pass message not found in $LOG"
    exit 1
fi

// ==== src.f ====
mmi_pkg.sv
dvbs2x_sample_pkg.sv
symb_rate_regs.sv
rate_hold_stage.sv
tx_sample_egress.sv
dvbs2x_tx_symb_rate_divider_mmi.sv
tb_symb_rate_divider.sv

// ==== symb_rate_regs.sv ====
// ##############################
// symbol rate register block with
// rate decode and stage enables.
// ##############################

`timescale 1ns/1ps
`default_nettype none

module symb_rate_regs (
    input  logic                                         clk_mmi,
    input  logic                                         sresetn_mmi_interconnect,
    input  mmi_pkg::mmi_req_t                            mmi_req,
    output mmi_pkg::mmi_rsp_t                            mmi_rsp,
    output logic [dvbs2x_sample_pkg::NUM_HOLD_STAGES-1:0] hold_en
);

    import mmi_pkg::*;
    import dvbs2x_sample_pkg::*;

    logic [MMI_DATA_NB-1:0] mmi_regs [0:TOTAL_MMI_REGS-1]; // rate and selection words.
    logic                   rd_valid;                       // read response pending.
    logic [MMI_DATA_NB-1:0] rd_data;
    symb_rate_sel_t         rate_sel;                       // registered selection.

    // word address to array index.
    function automatic logic [MMI_REG_IDX_NB-1:0] reg_idx(
        input logic [MMI_ADDR_NB-1:0] addr
    );
        return addr[MMI_REG_IDX_NB-1:0];
    endfunction

    // rate table lookup that falls back to the default.
    function automatic symb_rate_sel_t symb_rate_to_sel(
        input logic [MMI_DATA_NB-1:0] rate_msps
    );
        symb_rate_sel_t sel;
        sel = DEFAULT_SYMB_RATE_SEL;
        for (int k = 0; k < NUM_TX_SYMB_RATES; k++) begin
            if (rate_msps == MMI_DATA_NB'(SYMB_RATE_MSPS[k])) begin
                sel = symb_rate_sel_t'(k);
            end
        end
        return sel;
    endfunction

    // only the rate register is writable.
    function automatic logic writable_reg(input logic [MMI_ADDR_NB-1:0] addr);
        return addr == ADDR_SYMB_RATE;
    endfunction

    function automatic logic undefined_addr(input logic [MMI_ADDR_NB-1:0] addr);
        return addr >= MMI_ADDR_NB'(TOTAL_MMI_REGS);
    endfunction

    // selection word trails the rate word by one edge.
    always_ff @(posedge clk_mmi) begin
        if (!sresetn_mmi_interconnect) begin
            mmi_regs[reg_idx(ADDR_SYMB_RATE)]     <=
                MMI_DATA_NB'(SYMB_RATE_MSPS[DEFAULT_SYMB_RATE_SEL]);
            mmi_regs[reg_idx(ADDR_SYMB_RATE_SEL)] <= MMI_DATA_NB'(DEFAULT_SYMB_RATE_SEL);
        end else begin
            if (mmi_req.wvalid && writable_reg(mmi_req.waddr)) begin
                mmi_regs[reg_idx(ADDR_SYMB_RATE)] <= mmi_req.wdata; // raw value kept.
            end
            mmi_regs[reg_idx(ADDR_SYMB_RATE_SEL)] <=
                MMI_DATA_NB'(symb_rate_to_sel(mmi_regs[reg_idx(ADDR_SYMB_RATE)]));
        end
    end

    // read handshake.
    always_ff @(posedge clk_mmi) begin
        if (!sresetn_mmi_interconnect) begin
            rd_valid <= 1'b0;
        end else if (mmi_req.arvalid) begin
            rd_valid <= 1'b1;                       // response next cycle.
        end else if (mmi_req.rready) begin
            rd_valid <= 1'b0;                       // host took it.
        end
    end

    // read data captured on request.
    always_ff @(posedge clk_mmi) begin
        if (mmi_req.arvalid) begin
            if (undefined_addr(mmi_req.raddr)) begin
                rd_data <= '0;
            end else begin
                rd_data <= mmi_regs[reg_idx(mmi_req.raddr)];
            end
        end
    end

    assign mmi_rsp = '{
        wready:  sresetn_mmi_interconnect,          // low while in reset.
        arready: sresetn_mmi_interconnect,
        rvalid:  rd_valid,
        rdata:   rd_data
    };

    assign rate_sel =
        symb_rate_sel_t'(mmi_regs[reg_idx(ADDR_SYMB_RATE_SEL)][SYMB_RATE_SEL_NB-1:0]);

    // quarter enables all stages, half the first, full none.
    always_comb begin
        for (int s = 0; s < NUM_HOLD_STAGES; s++) begin
            hold_en[s] = s < (NUM_HOLD_STAGES - int'(rate_sel));
        end
    end

endmodule

`default_nettype wire

// ==== tb_symb_rate_divider.sv ====
// ##############################
// testbench for the symbol rate divider
// with register, stream and stall tests.
// ##############################

`timescale 1ns/1ps
`default_nettype none

module tb_symb_rate_divider;

    import mmi_pkg::*;
    import dvbs2x_sample_pkg::*;

    localparam int CLK_PERIOD      = 10;
    localparam int RESET_CYCLES    = 5;
    localparam int BURST_LEN       = 16;
    localparam int THROUGHPUT_LEN  = 32;
    localparam int TOTAL_SAMPLES   = 3 * BURST_LEN + BURST_LEN + THROUGHPUT_LEN;
    localparam int WATCHDOG_CYCLES = 20 * TOTAL_SAMPLES;
    localparam int DRAIN_CYCLES    = 8;                 // quiet time after the last output.
    localparam int RATE_LIST [3]   = '{100, 50, 25};    // msps.
    localparam int REPEAT_LIST [3] = '{1, 2, 4};        // copies per sample at each rate.

    logic     clk_mmi;
    logic     sresetn_mmi_interconnect;
    mmi_req_t mmi_req;
    mmi_rsp_t mmi_rsp;
    sample_t  in_sample;
    logic     in_valid;
    logic     in_ready;
    sample_t  out_sample;
    logic     out_valid;
    logic     out_ready = 1'b1;

    integer   seed = 47;
    logic     stall_en = 1'b0;                          // random out_ready gaps.
    sample_t  stim_q [$];                               // current burst.
    sample_t  got_q [$];                                // collected outputs.

    dvbs2x_tx_symb_rate_divider_mmi dvbs2x_tx_symb_rate_divider_mmi_i (
        .clk_mmi                  (clk_mmi),
        .sresetn_mmi_interconnect (sresetn_mmi_interconnect),
        .mmi_req                  (mmi_req),
        .mmi_rsp                  (mmi_rsp),
        .in_sample                (in_sample),
        .in_valid                 (in_valid),
        .in_ready                 (in_ready),
        .out_sample               (out_sample),
        .out_valid                (out_valid),
        .out_ready                (out_ready)
    );

    initial begin
        clk_mmi = 1'b0;
        forever #(CLK_PERIOD / 2) clk_mmi = ~clk_mmi;
    end

    // out_ready for the next edge, and the sample that edge will take.
    always @(negedge clk_mmi) begin
        if (stall_en) out_ready = (($random(seed) & 3) != 0);
        else out_ready = 1'b1;
        if (sresetn_mmi_interconnect && out_valid && out_ready) got_q.push_back(out_sample);
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_mmi);
        $display("timeout, the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        abort_run();
    end

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("ERR time=%0t %s expected=0x%0h actual=0x%0h",
                     $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic write_reg(input logic [MMI_ADDR_NB-1:0] addr,
                             input logic [MMI_DATA_NB-1:0] data);
        @(negedge clk_mmi);
        compare_value("mmi_rsp.wready", 32'd1, 32'(mmi_rsp.wready));
        mmi_req.wvalid = 1'b1;
        mmi_req.waddr  = addr;
        mmi_req.wdata  = data;
        @(negedge clk_mmi);
        mmi_req.wvalid = 1'b0;                          // written on the edge between.
    endtask

    // selection and enables follow two edges after the write.
    task automatic set_rate(input int rate_msps);
        write_reg(ADDR_SYMB_RATE, 32'(rate_msps));
        repeat (2) @(negedge clk_mmi);
    endtask

    task automatic read_reg(input logic [MMI_ADDR_NB-1:0] addr, input int hold_cycles,
                            output logic [MMI_DATA_NB-1:0] data);
        @(negedge clk_mmi);
        compare_value("mmi_rsp.arready", 32'd1, 32'(mmi_rsp.arready));
        mmi_req.arvalid = 1'b1;
        mmi_req.raddr   = addr;
        @(negedge clk_mmi);
        mmi_req.arvalid = 1'b0;
        while (!mmi_rsp.rvalid) @(negedge clk_mmi);
        repeat (hold_cycles) begin                      // response must wait for rready.
            @(negedge clk_mmi);
            compare_value("mmi_rsp.rvalid", 32'd1, 32'(mmi_rsp.rvalid));
        end
        data = mmi_rsp.rdata;
        mmi_req.rready = 1'b1;
        @(negedge clk_mmi);
        mmi_req.rready = 1'b0;
        compare_value("mmi_rsp.rvalid", 32'd0, 32'(mmi_rsp.rvalid)); // taken.
    endtask

    task automatic read_and_compare(input logic [MMI_ADDR_NB-1:0] addr,
                                    input logic [MMI_DATA_NB-1:0] expected,
                                    input int hold_cycles);
        logic [MMI_DATA_NB-1:0] data;
        read_reg(addr, hold_cycles, data);
        compare_value($sformatf("mmi_rsp.rdata at address %0d", addr), expected, data);
    endtask

    task automatic make_burst(input int n);
        sample_t     s;
        logic [31:0] rnd;
        stim_q.delete();
        for (int k = 0; k < n; k++) begin
            rnd    = $random(seed);
            s.i    = rnd[15:0];
            s.q    = rnd[31:16];
            s.last = (k == n - 1);                      // burst end marker.
            stim_q.push_back(s);
        end
    endtask

    // must_flow demands in_ready high once outputs have started.
    task automatic send_stim(input bit must_flow);
        bit flowing;
        flowing = 1'b0;
        @(negedge clk_mmi);
        foreach (stim_q[k]) begin
            in_sample = stim_q[k];
            in_valid  = 1'b1;
            flowing   = flowing || out_valid;
            if (must_flow && flowing) compare_value("in_ready", 32'd1, 32'(in_ready));
            while (!in_ready) @(negedge clk_mmi);
            @(negedge clk_mmi);                         // taken on the edge between.
        end
        in_valid = 1'b0;
    endtask

    // each input repeated reps times, last only on the final copy.
    task automatic expect_stream(input int reps);
        sample_t exp_q [$];
        sample_t e;
        foreach (stim_q[k]) begin
            for (int c = 0; c < reps; c++) begin
                e      = stim_q[k];
                e.last = stim_q[k].last && (c == reps - 1);
                exp_q.push_back(e);
            end
        end
        while (got_q.size() < exp_q.size()) @(negedge clk_mmi);
        repeat (DRAIN_CYCLES) @(negedge clk_mmi);
        compare_value("output sample count", 32'(exp_q.size()), 32'(got_q.size()));
        foreach (exp_q[k]) begin
            compare_value($sformatf("out_sample[%0d].i", k), 32'(exp_q[k].i), 32'(got_q[k].i));
            compare_value($sformatf("out_sample[%0d].q", k), 32'(exp_q[k].q), 32'(got_q[k].q));
            compare_value($sformatf("out_sample[%0d].last", k),
                          32'(exp_q[k].last), 32'(got_q[k].last));
        end
        got_q.delete();
    endtask

    task automatic reset_state();
        sresetn_mmi_interconnect = 1'b0;
        repeat (RESET_CYCLES) begin
            @(negedge clk_mmi);
            compare_value("out_valid", 32'd0, 32'(out_valid));
            compare_value("mmi_rsp.rvalid", 32'd0, 32'(mmi_rsp.rvalid));
            compare_value("mmi_rsp.wready", 32'd0, 32'(mmi_rsp.wready));
            compare_value("mmi_rsp.arready", 32'd0, 32'(mmi_rsp.arready));
        end
        sresetn_mmi_interconnect = 1'b1;
        read_and_compare(ADDR_SYMB_RATE, 32'd100, 0);
        read_and_compare(ADDR_SYMB_RATE_SEL, 32'(TX_SYMB_RATE_FULL), 0);
    endtask

    task automatic register_access();
        set_rate(50);
        read_and_compare(ADDR_SYMB_RATE, 32'd50, 3);
        read_and_compare(ADDR_SYMB_RATE_SEL, 32'(TX_SYMB_RATE_HALF), 0);
        write_reg(ADDR_SYMB_RATE_SEL, 32'd25);          // read-only, no effect.
        repeat (2) @(negedge clk_mmi);
        read_and_compare(ADDR_SYMB_RATE, 32'd50, 0);
        read_and_compare(ADDR_SYMB_RATE_SEL, 32'(TX_SYMB_RATE_HALF), 0);
        read_and_compare(8'd5, 32'd0, 0);               // unmapped.
        set_rate(77);                                   // unknown rate.
        read_and_compare(ADDR_SYMB_RATE, 32'd77, 0);
        read_and_compare(ADDR_SYMB_RATE_SEL, 32'(TX_SYMB_RATE_FULL), 1);
    endtask

    task automatic rate_repetition();
        for (int k = 0; k < 3; k++) begin
            set_rate(RATE_LIST[k]);
            make_burst(BURST_LEN);
            send_stim(1'b0);
            expect_stream(REPEAT_LIST[k]);
        end
    endtask

    task automatic back_pressure();
        set_rate(25);
        make_burst(BURST_LEN);
        @(posedge clk_mmi);
        stall_en = 1'b1;
        send_stim(1'b0);
        expect_stream(4);
        @(posedge clk_mmi);
        stall_en = 1'b0;
    endtask

    task automatic full_rate_throughput();
        set_rate(100);
        make_burst(THROUGHPUT_LEN);
        send_stim(1'b1);
        expect_stream(1);
    endtask

    initial begin
        sresetn_mmi_interconnect = 1'b0;
        mmi_req   = '0;
        in_sample = '0;
        in_valid  = 1'b0;
        reset_state();
        register_access();
        rate_repetition();
        back_pressure();
        full_rate_throughput();
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tx_sample_egress.sv ====
// ##############################
// two-entry skid buffer on the
// stream output.
// ##############################

`timescale 1ns/1ps
`default_nettype none

module tx_sample_egress (
    input  logic                       clk_mmi,
    input  logic                       sresetn_mmi_interconnect,
    input  dvbs2x_sample_pkg::sample_t in_sample,
    input  logic                       in_valid,
    output logic                       in_ready,
    output dvbs2x_sample_pkg::sample_t out_sample,
    output logic                       out_valid,
    input  logic                       out_ready
);

    import dvbs2x_sample_pkg::*;

    sample_t    mem [0:1];                          // skid entries.
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;                              // entries held, 0 to 2.
    logic [1:0] count_next;
    logic       push;
    logic       pop;

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_comb begin
        case ({push, pop})
            2'b10:   count_next = count + 2'd1;
            2'b01:   count_next = count - 2'd1;
            default: count_next = count;            // idle or pass-through.
        endcase
    end

    // pointers, count and the registered ready.
    always_ff @(posedge clk_mmi) begin
        if (!sresetn_mmi_interconnect) begin
            wr_ptr   <= 1'b0;
            rd_ptr   <= 1'b0;
            count    <= 2'd0;
            in_ready <= 1'b1;                       // empty.
        end else begin
            if (push) wr_ptr <= !wr_ptr;
            if (pop) rd_ptr <= !rd_ptr;
            count    <= count_next;
            in_ready <= count_next != 2'd2;         // drops only when full.
        end
    end

    always_ff @(posedge clk_mmi) begin
        if (push) begin
            mem[wr_ptr] <= in_sample;
        end
    end

    assign out_valid  = count != 2'd0;
    assign out_sample = mem[rd_ptr];                // oldest entry.

endmodule

`default_nettype wire
